//--- compile.f
rtl/standby_pkg.sv
rtl/bus_monitor.sv
rtl/tti_queue.sv
rtl/i2c_target_rx.sv
rtl/i3c_target_rx.sv
rtl/standby_csr.sv
rtl/controller_standby.sv
rtl/standby_top.sv
test/standby_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module standby_tb
	out="$$(./obj_dir/Vstandby_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- test/standby_stimulus.txt
# ctrl dyn_reg pin addr_byte count d0 d1 d2 d3 d4 d5 d6 d7 d8 ack desc bad
# ack bit 0 is the address, bit n is data byte n-1; desc 0 means none; bad ff means no corrupt T bit
01 00 0 74 3 11 22 33 00 00 00 00 00 00 00f 00740003 ff
01 00 0 52 2 44 55 00 00 00 00 00 00 00 000 00000000 ff
01 00 0 75 1 66 00 00 00 00 00 00 00 00 000 00000000 ff
01 00 0 74 1 a5 00 00 00 00 00 00 00 00 003 00740001 ff
03 ab 1 56 4 de ad be ef 00 00 00 00 00 001 80560004 ff
03 2b 1 56 2 12 34 00 00 00 00 00 00 00 000 00000000 ff
03 fe 1 fc 2 12 34 00 00 00 00 00 00 00 000 00000000 ff
03 ab 1 56 3 01 02 03 00 00 00 00 00 00 001 c0560002 01
01 ab 0 74 9 01 02 03 04 05 06 07 08 09 1ff 20740008 ff
03 ab 1 56 9 f0 e1 d2 c3 b4 a5 96 87 78 001 a0560008 ff
03 ab 0 74 2 5a 3c 00 00 00 00 00 00 00 000 00000000 ff
01 ab 1 56 2 5a 3c 00 00 00 00 00 00 00 000 00000000 ff
00 ab 0 74 2 5a 3c 00 00 00 00 00 00 00 000 00000000 ff
02 ab 1 56 1 77 00 00 00 00 00 00 00 00 000 00000000 ff
01 ab 0 74 2 c6 39 00 00 00 00 00 00 00 007 00740002 ff

//--- test/standby_tb.sv
`timescale 1ns/1ps
// Self-checking testbench for standby_top, replaying the transfers listed in the stimulus file
module standby_tb;

  localparam int MaxTransfers = 32;
  localparam int MaxBytes = 9;
  // Setup, start, ten frames, stop, descriptor wait and drain
  localparam int TransferClocks = 1200;

  logic                                 clk;
  logic                                 rst_n;
  logic [standby_pkg::ApbAddrWidth-1:0] paddr;
  logic                                 psel;
  logic                                 penable;
  logic                                 pwrite;
  logic [31:0]                          pwdata;
  logic [31:0]                          prdata;
  logic                                 pready;
  logic                                 pslverr;
  logic                                 host_scl[2];
  logic                                 host_sda[2];
  logic                                 sda_line[2];
  logic                                 sda_pull[2];
  logic                                 data_rvalid;
  logic                                 data_rready;
  logic [7:0]                           data_rdata;
  logic                                 desc_rvalid;
  logic                                 desc_rready;
  logic [31:0]                          desc_rdata;

  logic [7:0]  st_ctrl [MaxTransfers];
  logic [7:0]  st_dyn [MaxTransfers];
  logic [7:0]  st_pin [MaxTransfers];
  logic [7:0]  st_addr [MaxTransfers];
  logic [7:0]  st_count [MaxTransfers];
  logic [7:0]  st_data [MaxTransfers][MaxBytes];
  logic [15:0] st_ack [MaxTransfers];
  logic [31:0] st_desc [MaxTransfers];
  logic [7:0]  st_bad [MaxTransfers];
  int          num_transfers;
  bit          loaded;
  int          errors;
  int          checks;
  logic [31:0] lfsr;

  // Open-drain wired AND of host and target
  assign sda_line[0] = host_sda[0] & ~sda_pull[0];
  assign sda_line[1] = host_sda[1] & ~sda_pull[1];

  standby_top standby_top_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .paddr_i          (paddr),
    .psel_i           (psel),
    .penable_i        (penable),
    .pwrite_i         (pwrite),
    .pwdata_i         (pwdata),
    .prdata_o         (prdata),
    .pready_o         (pready),
    .pslverr_o        (pslverr),
    .scl_i            (host_scl),
    .sda_i            (sda_line),
    .sda_pull_o       (sda_pull),
    .rx_data_rvalid_o (data_rvalid),
    .rx_data_rready_i (data_rready),
    .rx_data_rdata_o  (data_rdata),
    .rx_desc_rvalid_o (desc_rvalid),
    .rx_desc_rready_i (desc_rready),
    .rx_desc_rdata_o  (desc_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_event(input string what, input bit ok);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Error at %0d ns: %s", $time, what);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic int take_bits(input int n);
    int value;
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic load_stimulus();
    int    fd;
    int    code;
    int    b;
    string line;
    fd = $fopen("test/standby_stimulus.txt", "r");
    num_transfers = 0;
    if (fd != 0) begin
      while ($fgets(line, fd) != 0 && num_transfers < MaxTransfers) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          b = num_transfers;
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         st_ctrl[b], st_dyn[b], st_pin[b], st_addr[b], st_count[b],
                         st_data[b][0], st_data[b][1], st_data[b][2], st_data[b][3],
                         st_data[b][4], st_data[b][5], st_data[b][6], st_data[b][7],
                         st_data[b][8], st_ack[b], st_desc[b], st_bad[b]);
          if (code == 17) begin
            num_transfers++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apb_access(input logic [standby_pkg::ApbAddrWidth-1:0] addr,
                            input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    paddr = addr;
    pwrite = write;
    pwdata = wdata;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #25;
    rdata = prdata;
    err = pslverr;
    check_value("pready_o", 32'h1, {31'b0, pready});
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [standby_pkg::ApbAddrWidth-1:0] addr,
                           input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    check_value("pslverr_o", exp_err, err);
  endtask

  task automatic apb_read_check(input logic [standby_pkg::ApbAddrWidth-1:0] addr,
                                input logic [31:0] expected, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, '0, rdata, err);
    check_value("pslverr_o", exp_err, err);
    if (!exp_err) begin
      check_value("prdata_o", expected, rdata);
    end
  endtask

  task automatic check_registers();
    apb_read_check(standby_pkg::RegCtrl, 32'h0, 1'b0);
    apb_read_check(standby_pkg::RegStaAddr, 32'h50, 1'b0);
    apb_read_check(standby_pkg::RegDynAddr, 32'h0, 1'b0);
    apb_read_check(standby_pkg::RegStatus, 32'h0, 1'b0);
    apb_write(standby_pkg::RegStaAddr, 32'h3a, 1'b0);
    apb_read_check(standby_pkg::RegStaAddr, 32'h3a, 1'b0);
    apb_write(standby_pkg::RegDynAddr, 32'hab, 1'b0);
    apb_read_check(standby_pkg::RegDynAddr, 32'hab, 1'b0);
    apb_write(standby_pkg::RegCtrl, 32'h3, 1'b0);
    apb_read_check(standby_pkg::RegCtrl, 32'h3, 1'b0);
    apb_write(standby_pkg::RegCtrl, 32'h0, 1'b0);
    apb_write(standby_pkg::RegStatus, 32'hf0f, 1'b1);
    apb_read_check(standby_pkg::RegStatus, 32'h0, 1'b0);
    apb_read_check(4'd2, 32'h0, 1'b1);
    apb_write(4'd6, 32'h1, 1'b1);
    apb_read_check(standby_pkg::RegStaAddr, 32'h3a, 1'b0);
  endtask

  task automatic bus_start(input int p);
    host_sda[p] = 1'b0;
    wait_clocks(4);
    host_scl[p] = 1'b0;
  endtask

  // SCL low and high phases of four clocks each
  task automatic send_bit(input int p, input logic b, output logic pulled);
    wait_clocks(2);
    host_sda[p] = b;
    wait_clocks(2);
    host_scl[p] = 1'b1;
    wait_clocks(2);
    pulled = sda_pull[p];
    wait_clocks(2);
    host_scl[p] = 1'b0;
  endtask

  task automatic send_byte(input int p, input logic [7:0] data, input logic ninth,
                           output logic pulled);
    int   i;
    logic unused;
    for (i = 7; i >= 0; i--) begin
      send_bit(p, data[i], unused);
    end
    send_bit(p, ninth, pulled);
  endtask

  task automatic bus_stop(input int p);
    wait_clocks(2);
    host_sda[p] = 1'b0;
    wait_clocks(2);
    host_scl[p] = 1'b1;
    wait_clocks(4);
    host_sda[p] = 1'b1;
    wait_clocks(4);
  endtask

  task automatic run_transfer(input int t);
    logic [7:0]  expected_bytes[$];
    logic [15:0] acks;
    logic        ack;
    logic        tbit;
    logic [3:0]  desc_level;
    bit          got_desc;
    int          gap;
    int          i;
    int          p;
    p = int'(st_pin[t]);
    acks = '0;
    apb_write(standby_pkg::RegDynAddr, {24'b0, st_dyn[t]}, 1'b0);
    apb_write(standby_pkg::RegCtrl, {24'b0, st_ctrl[t]}, 1'b0);
    gap = take_bits(3);
    wait_clocks(4 + gap);
    bus_start(p);
    send_byte(p, st_addr[t], 1'b1, ack);
    acks[0] = ack;
    for (i = 0; i < int'(st_count[t]); i++) begin
      // I3C host sends an odd parity T bit where I2C releases for the ACK
      tbit = (p == 1) ? ~^st_data[t][i] : 1'b1;
      if (i == int'(st_bad[t])) begin
        tbit = ~tbit;
      end
      send_byte(p, st_data[t][i], tbit, ack);
      acks[i+1] = ack;
      if (st_desc[t] != '0 && i != int'(st_bad[t]) &&
          expected_bytes.size() < standby_pkg::QueueDepth) begin
        expected_bytes.push_back(st_data[t][i]);
      end
    end
    bus_stop(p);
    check_value("sda_pull_o (ACK bits)", {16'b0, st_ack[t]}, {16'b0, acks});
    if (st_desc[t] != '0) begin
      got_desc = 1'b0;
      for (i = 0; i < 200 && !got_desc; i++) begin
        @(negedge clk);
        got_desc = desc_rvalid;
      end
      check_event("no descriptor was written after the stop", got_desc);
      desc_level = 4'd1;
    end else begin
      wait_clocks(16);
      desc_level = 4'd0;
    end
    apb_read_check(standby_pkg::RegStatus,
                   {20'b0, desc_level, 4'b0, 4'(expected_bytes.size())}, 1'b0);
    gap = take_bits(3);
    wait_clocks(gap);
    for (i = 0; i < expected_bytes.size(); i++) begin
      check_value("rx_data_rvalid_o", 32'h1, data_rvalid);
      check_value("rx_data_rdata_o", expected_bytes[i], data_rdata);
      data_rready = 1'b1;
      @(negedge clk);
      data_rready = 1'b0;
    end
    check_value("rx_data_rvalid_o", 32'h0, data_rvalid);
    if (st_desc[t] != '0) begin
      check_value("rx_desc_rdata_o", st_desc[t], desc_rdata);
      desc_rready = 1'b1;
      @(negedge clk);
      desc_rready = 1'b0;
    end
    check_value("rx_desc_rvalid_o", 32'h0, desc_rvalid);
  endtask

  initial begin
    int t;
    rst_n = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    host_scl[0] = 1'b1;
    host_scl[1] = 1'b1;
    host_sda[0] = 1'b1;
    host_sda[1] = 1'b1;
    data_rready = 1'b0;
    desc_rready = 1'b0;
    errors = 0;
    checks = 0;
    lfsr = 32'h73ca;
    load_stimulus();
    loaded = 1'b1;
    wait_clocks(16);
    rst_n = 1'b1;
    wait_clocks(2);
    if (num_transfers == 0) begin
      $display("Error: no transfers could be read from test/standby_stimulus.txt");
      errors++;
    end else begin
      check_registers();
      for (t = 0; t < num_transfers; t++) begin
        run_transfer(t);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the number of transfers read
  initial begin
    wait (loaded);
    repeat (num_transfers * TransferClocks + 4000) @(posedge clk);
    $display("Error: the run did not finish within its time limit");
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- rtl/standby_top.sv
`timescale 1ns/1ps
// Top level of the standby target, APB configured with RX queues drained by valid/ready
module standby_top (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [standby_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [31:0]                          pwdata_i,
  output logic [31:0]                          prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  input  logic                                 scl_i[2],
  input  logic                                 sda_i[2],
  output logic                                 sda_pull_o[2],
  output logic                                 rx_data_rvalid_o,
  input  logic                                 rx_data_rready_i,
  output logic [standby_pkg::DataWidth-1:0]    rx_data_rdata_o,
  output logic                                 rx_desc_rvalid_o,
  input  logic                                 rx_desc_rready_i,
  output logic [standby_pkg::DescWidth-1:0]    rx_desc_rdata_o
);

  logic                               enable;
  logic                               i3c_mode;
  logic [6:0]                         sta_addr;
  logic [6:0]                         dyn_addr;
  logic                               dyn_addr_valid;
  logic                               data_full;
  logic                               data_wvalid;
  logic [standby_pkg::DataWidth-1:0]  data_wdata;
  logic                               desc_wvalid;
  standby_pkg::desc_t                 desc_wdata;
  logic [standby_pkg::LevelWidth-1:0] data_level;
  logic [standby_pkg::LevelWidth-1:0] desc_level;

  standby_csr standby_csr_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .paddr_i          (paddr_i),
    .psel_i           (psel_i),
    .penable_i        (penable_i),
    .pwrite_i         (pwrite_i),
    .pwdata_i         (pwdata_i),
    .prdata_o         (prdata_o),
    .pready_o         (pready_o),
    .pslverr_o        (pslverr_o),
    .data_level_i     (data_level),
    .desc_level_i     (desc_level),
    .enable_o         (enable),
    .i3c_mode_o       (i3c_mode),
    .sta_addr_o       (sta_addr),
    .dyn_addr_o       (dyn_addr),
    .dyn_addr_valid_o (dyn_addr_valid)
  );

  controller_standby controller_standby_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .enable_i         (enable),
    .i3c_mode_i       (i3c_mode),
    .sta_addr_i       (sta_addr),
    .dyn_addr_i       (dyn_addr),
    .dyn_addr_valid_i (dyn_addr_valid),
    .scl_i            (scl_i),
    .sda_i            (sda_i),
    .data_full_i      (data_full),
    .sda_pull_o       (sda_pull_o),
    .data_wvalid_o    (data_wvalid),
    .data_wdata_o     (data_wdata),
    .desc_wvalid_o    (desc_wvalid),
    .desc_wdata_o     (desc_wdata)
  );

  tti_queue #(
    .entry_t (logic [standby_pkg::DataWidth-1:0])
  ) data_queue_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (data_wvalid),
    .wdata_i  (data_wdata),
    .rready_i (rx_data_rready_i),
    .full_o   (data_full),
    .rvalid_o (rx_data_rvalid_o),
    .rdata_o  (rx_data_rdata_o),
    .level_o  (data_level)
  );

  // A full descriptor queue drops the write
  tti_queue #(
    .entry_t (standby_pkg::desc_t)
  ) desc_queue_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (desc_wvalid),
    .wdata_i  (desc_wdata),
    .rready_i (rx_desc_rready_i),
    .full_o   (),
    .rvalid_o (rx_desc_rvalid_o),
    .rdata_o  (rx_desc_rdata_o),
    .level_o  (desc_level)
  );

endmodule

//--- rtl/controller_standby.sv
`timescale 1ns/1ps
// Standby controller that runs one of the two target engines and grants it the RX queues
module controller_standby (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              enable_i,
  input  logic                              i3c_mode_i,
  input  logic [6:0]                        sta_addr_i,
  input  logic [6:0]                        dyn_addr_i,
  input  logic                              dyn_addr_valid_i,
  input  logic                              scl_i[2],
  input  logic                              sda_i[2],
  input  logic                              data_full_i,
  output logic                              sda_pull_o[2],
  output logic                              data_wvalid_o,
  output logic [standby_pkg::DataWidth-1:0] data_wdata_o,
  output logic                              desc_wvalid_o,
  output standby_pkg::desc_t                desc_wdata_o
);

  logic                              i2c_en;
  logic                              i3c_en;
  logic                              i2c_pull;
  logic                              i3c_pull;
  logic                              i2c_data_wvalid;
  logic                              i3c_data_wvalid;
  logic [standby_pkg::DataWidth-1:0] i2c_data_wdata;
  logic [standby_pkg::DataWidth-1:0] i3c_data_wdata;
  logic                              i2c_desc_wvalid;
  logic                              i3c_desc_wvalid;
  standby_pkg::desc_t                i2c_desc_wdata;
  standby_pkg::desc_t                i3c_desc_wdata;

  // Only one protocol is active, so the mode bit is the grant
  assign i2c_en = enable_i & ~i3c_mode_i;
  assign i3c_en = enable_i & i3c_mode_i;

  always_comb begin
    data_wvalid_o = i3c_mode_i ? i3c_data_wvalid : i2c_data_wvalid;
    data_wdata_o = i3c_mode_i ? i3c_data_wdata : i2c_data_wdata;
    desc_wvalid_o = i3c_mode_i ? i3c_desc_wvalid : i2c_desc_wvalid;
    desc_wdata_o = i3c_mode_i ? i3c_desc_wdata : i2c_desc_wdata;
    sda_pull_o[0] = i2c_en & i2c_pull;
    sda_pull_o[1] = i3c_en & i3c_pull;
  end

  i2c_target_rx i2c_target_rx_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .enable_i      (i2c_en),
    .sta_addr_i    (sta_addr_i),
    .scl_i         (scl_i[0]),
    .sda_i         (sda_i[0]),
    .sda_pull_o    (i2c_pull),
    .data_wvalid_o (i2c_data_wvalid),
    .data_wdata_o  (i2c_data_wdata),
    .desc_wvalid_o (i2c_desc_wvalid),
    .desc_wdata_o  (i2c_desc_wdata),
    .data_full_i   (data_full_i)
  );

  i3c_target_rx i3c_target_rx_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .enable_i         (i3c_en),
    .dyn_addr_i       (dyn_addr_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .scl_i            (scl_i[1]),
    .sda_i            (sda_i[1]),
    .sda_pull_o       (i3c_pull),
    .data_wvalid_o    (i3c_data_wvalid),
    .data_wdata_o     (i3c_data_wdata),
    .desc_wvalid_o    (i3c_desc_wvalid),
    .desc_wdata_o     (i3c_desc_wdata),
    .data_full_i      (data_full_i)
  );

endmodule

//--- rtl/standby_csr.sv
`timescale 1ns/1ps
// APB register block with the standby control, address and queue status registers
module standby_csr (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [standby_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [31:0]                          pwdata_i,
  output logic [31:0]                          prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  input  logic [standby_pkg::LevelWidth-1:0]   data_level_i,
  input  logic [standby_pkg::LevelWidth-1:0]   desc_level_i,
  output logic                                 enable_o,
  output logic                                 i3c_mode_o,
  output logic [6:0]                           sta_addr_o,
  output logic [6:0]                           dyn_addr_o,
  output logic                                 dyn_addr_valid_o
);

  logic access;
  logic addr_ok;
  logic wr_en;

  always_comb begin
    addr_ok = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      standby_pkg::RegCtrl:    prdata_o = {30'b0, i3c_mode_o, enable_o};
      standby_pkg::RegStaAddr: prdata_o = {25'b0, sta_addr_o};
      standby_pkg::RegDynAddr: prdata_o = {24'b0, dyn_addr_valid_o, dyn_addr_o};
      standby_pkg::RegStatus:  prdata_o = {20'b0, desc_level_i, 4'b0, data_level_i};
      default:                 addr_ok = 1'b0;
    endcase
  end

  assign access = psel_i & penable_i;
  assign pready_o = 1'b1;
  // Status is read-only
  assign pslverr_o = access & (~addr_ok | (pwrite_i & (paddr_i == standby_pkg::RegStatus)));
  assign wr_en = access & pwrite_i & ~pslverr_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_o <= 1'b0;
      i3c_mode_o <= 1'b0;
      sta_addr_o <= standby_pkg::ResetStaAddr;
      dyn_addr_o <= '0;
      dyn_addr_valid_o <= 1'b0;
    end else if (wr_en) begin
      case (paddr_i)
        standby_pkg::RegCtrl: begin
          enable_o <= pwdata_i[0];
          i3c_mode_o <= pwdata_i[1];
        end
        standby_pkg::RegStaAddr: sta_addr_o <= pwdata_i[6:0];
        standby_pkg::RegDynAddr: begin
          dyn_addr_o <= pwdata_i[6:0];
          dyn_addr_valid_o <= pwdata_i[7];
        end
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/i3c_target_rx.sv
`timescale 1ns/1ps
// I3C SDR private-write receiver, instantiated by the standby controller on the I3C pin pair
module i3c_target_rx (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              enable_i,
  input  logic [6:0]                        dyn_addr_i,
  input  logic                              dyn_addr_valid_i,
  input  logic                              scl_i,
  input  logic                              sda_i,
  output logic                              sda_pull_o,
  output logic                              data_wvalid_o,
  output logic [standby_pkg::DataWidth-1:0] data_wdata_o,
  output logic                              desc_wvalid_o,
  output standby_pkg::desc_t                desc_wdata_o,
  input  logic                              data_full_i
);

  typedef enum logic [1:0] {StIdle, StAddr, StData, StIgnore} state_e;

  state_e      state_q;
  logic        sda_s;
  logic        scl_rise;
  logic        scl_fall;
  logic        start;
  logic        rstart;
  logic        stop;
  logic [3:0]  bit_cnt_q;
  logic [7:0]  shift_q;
  logic [7:0]  addr_byte_q;
  logic [15:0] count_q;
  logic        overflow_q;
  logic        parity_err_q;
  logic        addr_match;
  logic        parity_ok;

  bus_monitor bus_monitor_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_o      (),
    .sda_o      (sda_s),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .start_o    (start),
    .rstart_o   (rstart),
    .stop_o     (stop)
  );

  // No CCC support, so the broadcast address is never claimed
  assign addr_match = dyn_addr_valid_i && (shift_q[7:1] == dyn_addr_i) && !shift_q[0] &&
                      (shift_q[7:1] != standby_pkg::I3cBroadcast);
  // T bit gives odd parity over the byte
  assign parity_ok = ^{shift_q, sda_s};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      bit_cnt_q <= '0;
      sda_pull_o <= 1'b0;
      data_wvalid_o <= 1'b0;
      desc_wvalid_o <= 1'b0;
      count_q <= '0;
      overflow_q <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      data_wvalid_o <= 1'b0;
      desc_wvalid_o <= 1'b0;
      if (!enable_i) begin
        state_q <= StIdle;
        sda_pull_o <= 1'b0;
      end else if (start || rstart || stop) begin
        desc_wvalid_o <= (state_q == StData);
        state_q <= stop ? StIdle : StAddr;
        bit_cnt_q <= '0;
        sda_pull_o <= 1'b0;
        count_q <= '0;
        overflow_q <= 1'b0;
        parity_err_q <= 1'b0;
      end else if (state_q == StAddr || state_q == StData) begin
        if (scl_rise) begin
          if (bit_cnt_q == 4'd8) begin
            bit_cnt_q <= '0;
            if (state_q == StAddr) begin
              state_q <= sda_pull_o ? StData : StIgnore;
            end else if (!parity_ok) begin
              parity_err_q <= 1'b1;
            end else if (data_full_i) begin
              overflow_q <= 1'b1;
            end else begin
              data_wvalid_o <= 1'b1;
              count_q <= count_q + 16'd1;
            end
          end else begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
          end
        end
        // Only the address byte gets an ACK from the target
        if (scl_fall) begin
          sda_pull_o <= (state_q == StAddr) && (bit_cnt_q == 4'd8) && addr_match;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && bit_cnt_q != 4'd8) begin
      shift_q <= {shift_q[6:0], sda_s};
    end
    if (scl_rise && bit_cnt_q == 4'd8) begin
      data_wdata_o <= shift_q;
      if (state_q == StAddr) begin
        addr_byte_q <= shift_q;
      end
    end
    desc_wdata_o <= '{proto: 1'b1, parity_err: parity_err_q, overflow: overflow_q,
                      reserved: '0, addr_byte: addr_byte_q, byte_count: count_q};
  end

endmodule

//--- rtl/i2c_target_rx.sv
`timescale 1ns/1ps
// I2C write receiver, instantiated by the standby controller on the I2C pin pair
module i2c_target_rx (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              enable_i,
  input  logic [6:0]                        sta_addr_i,
  input  logic                              scl_i,
  input  logic                              sda_i,
  output logic                              sda_pull_o,
  output logic                              data_wvalid_o,
  output logic [standby_pkg::DataWidth-1:0] data_wdata_o,
  output logic                              desc_wvalid_o,
  output standby_pkg::desc_t                desc_wdata_o,
  input  logic                              data_full_i
);

  typedef enum logic [1:0] {StIdle, StAddr, StData, StIgnore} state_e;

  state_e      state_q;
  logic        sda_s;
  logic        scl_rise;
  logic        scl_fall;
  logic        start;
  logic        rstart;
  logic        stop;
  logic [3:0]  bit_cnt_q;
  logic [7:0]  shift_q;
  logic [7:0]  addr_byte_q;
  logic [15:0] count_q;
  logic        overflow_q;
  logic        addr_match;

  bus_monitor bus_monitor_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_o      (),
    .sda_o      (sda_s),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .start_o    (start),
    .rstart_o   (rstart),
    .stop_o     (stop)
  );

  // Writes only
  assign addr_match = (shift_q[7:1] == sta_addr_i) && !shift_q[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      bit_cnt_q <= '0;
      sda_pull_o <= 1'b0;
      data_wvalid_o <= 1'b0;
      desc_wvalid_o <= 1'b0;
      count_q <= '0;
      overflow_q <= 1'b0;
    end else begin
      data_wvalid_o <= 1'b0;
      desc_wvalid_o <= 1'b0;
      if (!enable_i) begin
        state_q <= StIdle;
        sda_pull_o <= 1'b0;
      end else if (start || rstart || stop) begin
        // Descriptor only for a transfer whose address was ACKed
        desc_wvalid_o <= (state_q == StData);
        state_q <= stop ? StIdle : StAddr;
        bit_cnt_q <= '0;
        sda_pull_o <= 1'b0;
        count_q <= '0;
        overflow_q <= 1'b0;
      end else if (state_q == StAddr || state_q == StData) begin
        if (scl_rise) begin
          if (bit_cnt_q == 4'd8) begin
            bit_cnt_q <= '0;
            if (state_q == StAddr) begin
              state_q <= sda_pull_o ? StData : StIgnore;
            end else if (sda_pull_o) begin
              data_wvalid_o <= 1'b1;
              count_q <= count_q + 16'd1;
            end
          end else begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
          end
        end
        if (scl_fall) begin
          if (bit_cnt_q != 4'd8) begin
            sda_pull_o <= 1'b0;
          end else if (state_q == StAddr) begin
            sda_pull_o <= addr_match;
          end else begin
            sda_pull_o <= !data_full_i;
            overflow_q <= overflow_q | data_full_i;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && bit_cnt_q != 4'd8) begin
      shift_q <= {shift_q[6:0], sda_s};
    end
    if (scl_rise && bit_cnt_q == 4'd8) begin
      data_wdata_o <= shift_q;
      if (state_q == StAddr) begin
        addr_byte_q <= shift_q;
      end
    end
    desc_wdata_o <= '{proto: 1'b0, parity_err: 1'b0, overflow: overflow_q, reserved: '0,
                      addr_byte: addr_byte_q, byte_count: count_q};
  end

endmodule

//--- rtl/tti_queue.sv
`timescale 1ns/1ps
// First-word fall-through FIFO for target receive entries; entry_t picks the payload
module tti_queue #(
  parameter type entry_t = logic [7:0]
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               wvalid_i,
  input  entry_t                             wdata_i,
  input  logic                               rready_i,
  output logic                               full_o,
  output logic                               rvalid_o,
  output entry_t                             rdata_o,
  output logic [standby_pkg::LevelWidth-1:0] level_o
);

  entry_t                                     mem_q [standby_pkg::QueueDepth];
  logic [$clog2(standby_pkg::QueueDepth)-1:0] wptr_q;
  logic [$clog2(standby_pkg::QueueDepth)-1:0] rptr_q;
  logic                                       push;
  logic                                       pop;

  assign full_o = (level_o == standby_pkg::QueueDepth);
  assign rvalid_o = (level_o != '0);
  assign rdata_o = mem_q[rptr_q];
  assign push = wvalid_i & ~full_o;
  assign pop = rready_i & rvalid_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      level_o <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push && !pop) begin
        level_o <= level_o + 1'b1;
      end else if (pop && !push) begin
        level_o <= level_o - 1'b1;
      end
    end
  end

endmodule

//--- rtl/bus_monitor.sv
`timescale 1ns/1ps
// SCL/SDA synchronizer and bus condition detector, one per target engine
module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_o,
  output logic rstart_o,
  output logic stop_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_prev_q;
  logic       sda_prev_q;
  logic       open_q;
  logic       start_cond;
  logic       stop_cond;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      open_q <= 1'b0;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_sync_q[1];
      sda_prev_q <= sda_sync_q[1];
      if (start_cond) begin
        open_q <= 1'b1;
      end else if (stop_cond) begin
        open_q <= 1'b0;
      end
    end
  end

  assign scl_o = scl_sync_q[1];
  assign sda_o = sda_sync_q[1];
  assign scl_rise_o = scl_o & ~scl_prev_q;
  assign scl_fall_o = ~scl_o & scl_prev_q;

  // SDA moving while SCL stays high
  assign start_cond = scl_o & scl_prev_q & sda_prev_q & ~sda_o;
  assign stop_cond = scl_o & scl_prev_q & ~sda_prev_q & sda_o;

  assign start_o = start_cond & ~open_q;
  assign rstart_o = start_cond & open_q;
  assign stop_o = stop_cond;

endmodule

//--- rtl/standby_pkg.sv
// Shared constants and types for the standby target controller, referenced by scoped names
package standby_pkg;

  localparam int DataWidth = 8;
  localparam int DescWidth = 32;
  localparam int QueueDepth = 8;
  localparam int LevelWidth = 4;

  // One word per received transfer
  typedef struct packed {
    logic                 proto;
    logic                 parity_err;
    logic                 overflow;
    logic [4:0]           reserved;
    logic [7:0]           addr_byte;
    logic [15:0]          byte_count;
  } desc_t;

  localparam int ApbAddrWidth = 4;

  localparam logic [ApbAddrWidth-1:0] RegCtrl = 4'd0;
  localparam logic [ApbAddrWidth-1:0] RegStaAddr = 4'd4;
  localparam logic [ApbAddrWidth-1:0] RegDynAddr = 4'd8;
  localparam logic [ApbAddrWidth-1:0] RegStatus = 4'd12;

  localparam logic [6:0] ResetStaAddr = 7'h50;
  localparam logic [6:0] I3cBroadcast = 7'h7E;

endpackage
